// File: design/cmd_steer.sv
// greedy input steering: row hit, then empty, then below half, then not full, lowest index wins
`default_nettype none

`include "sched_params.svh"

module cmd_steer import sched_pkg::*; (
   input  logic                                    in_valid,
   input  mem_req_t                                in_req,
   input  logic [`NUM_QUEUES-1:0]                  empty,
   input  logic [`NUM_QUEUES-1:0]                  half,
   input  logic [`NUM_QUEUES-1:0]                  full,
   input  logic [`NUM_QUEUES-1:0][`ROW_BITS-1:0]   last_row,
   output logic                                    in_ready,
   output logic [`NUM_QUEUES-1:0]                  push     // one-hot, only on a transfer
);

   // read queues at the bottom, write queues above them
   localparam logic [`NUM_QUEUES-1:0] rd_group = {{`WR_QUEUES{1'b0}}, {`RD_QUEUES{1'b1}}};
   localparam logic [`NUM_QUEUES-1:0] wr_group = ~rd_group;

   logic [`NUM_QUEUES-1:0] kind_mask;   // queues that may take this request
   logic [`NUM_QUEUES-1:0] open_q;      // eligible and not full
   logic [`NUM_QUEUES-1:0] row_match;   // raw row compare per queue
   logic [`NUM_QUEUES-1:0] hit_q;       // step 1 candidates
   logic [`NUM_QUEUES-1:0] empty_q;     // step 2 candidates
   logic [`NUM_QUEUES-1:0] low_q;       // step 3 candidates
   logic [`NUM_QUEUES-1:0] pick;        // winning candidate set
   logic                   xfer;

   // keep only the lowest set bit, gives the one-hot push
   function automatic logic [`NUM_QUEUES-1:0] lowest_one(
      input logic [`NUM_QUEUES-1:0] vec
   );
      logic [`NUM_QUEUES-1:0] onehot;
      logic                   found;
      onehot = '0;
      found  = 1'b0;
      for (int i = 0; i < `NUM_QUEUES; i++) begin
         if (vec[i] && !found) begin
            onehot[i] = 1'b1;
            found     = 1'b1;
         end
      end
      return onehot;
   endfunction

   // restrict everything to the request's group
   assign kind_mask = (in_req.kind == kind_read) ? rd_group : wr_group;
   assign open_q    = kind_mask & ~full;

   // compare the incoming row against every queue's newest entry
   always_comb begin
      for (int i = 0; i < `NUM_QUEUES; i++) begin
         row_match[i] = (last_row[i] == in_req.row);
      end
   end

   // a hit only counts on a queue that holds something and can still take more
   assign hit_q   = open_q & ~empty & row_match;
   assign empty_q = kind_mask & empty;
   assign low_q   = kind_mask & ~half;          // below half is never full

   // four step priority, each step falls through when its set is empty
   always_comb begin
      if (|hit_q) begin
         pick = hit_q;
      end else if (|empty_q) begin
         pick = empty_q;
      end else if (|low_q) begin
         pick = low_q;
      end else begin
         pick = open_q;                         // any non-full queue, may be zero
      end
   end

   // ready follows the group's space only, no dependence on in_valid
   assign in_ready = |open_q;
   assign xfer     = in_valid && in_ready;

   assign push = xfer ? lowest_one(pick) : '0;

endmodule

`default_nettype wire

// File: design/issue_arbiter.sv
// round-robin pick among non-empty queue heads, presents one issue and pops it on a transfer
`default_nettype none

`include "sched_params.svh"

module issue_arbiter import sched_pkg::*; (
   input  logic                              clk,
   input  logic                              arst_n,
   input  mem_req_t [`NUM_QUEUES-1:0]        heads,
   input  logic [`NUM_QUEUES-1:0]            empty,
   input  logic                              out_ready,
   output logic                              out_valid,
   output issue_t                            out_issue,
   output logic [`NUM_QUEUES-1:0]            pop
);

   logic [`QIDX_BITS-1:0] rr_ptr;       // search start, first queue after last grant
   logic [`QIDX_BITS-1:0] search_idx;   // first non-empty at or after rr_ptr
   logic                  hold_q;       // output presented but not yet taken
   logic [`QIDX_BITS-1:0] hold_idx;     // queue locked while stalled
   logic [`QIDX_BITS-1:0] grant;
   logic                  xfer;

   // rotating search, wraps past the top queue
   always_comb begin
      int unsigned cand;
      logic        found;
      search_idx = '0;
      found      = 1'b0;
      for (int k = 0; k < `NUM_QUEUES; k++) begin
         cand = int'(rr_ptr) + k;
         if (cand >= `NUM_QUEUES) begin
            cand = cand - `NUM_QUEUES;
         end
         if (!found && !empty[cand]) begin
            search_idx = `QIDX_BITS'(cand);
            found      = 1'b1;
         end
      end
   end

   // a stalled head stays put even if an earlier queue fills meanwhile
   assign grant     = hold_q ? hold_idx : search_idx;
   assign out_valid = ~&empty;
   assign xfer      = out_valid && out_ready;

   assign out_issue.req       = heads[grant];
   assign out_issue.src_queue = grant;

   always_comb begin
      pop = '0;
      if (xfer) begin
         pop[grant] = 1'b1;
      end
   end

   // pointer advance and stall lock
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rr_ptr   <= '0;
         hold_q   <= 1'b0;
         hold_idx <= '0;
      end else if (xfer) begin
         rr_ptr <= (grant == `QIDX_BITS'(`NUM_QUEUES - 1)) ? '0 : grant + 1'b1;
         hold_q <= 1'b0;
      end else if (out_valid) begin
         hold_q   <= 1'b1;                    // keep the choice until accepted
         hold_idx <= grant;
      end
   end

endmodule

`default_nettype wire

// File: design/req_queue.sv
// request FIFO with empty / half / full flags and the newest row that the top instances per queue
`default_nettype none

`include "sched_params.svh"

module req_queue import sched_pkg::*; (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  push,     // one-hot bit from the steering logic
   input  logic                  pop,      // one-hot bit from the issue arbiter
   input  mem_req_t              wr_req,   // shared input request
   output mem_req_t              head,     // oldest entry
   output logic                  empty,
   output logic                  half,     // occupancy >= depth/2
   output logic                  full,
   output logic [`ROW_BITS-1:0]  last_row  // row of the newest entry
);

   localparam int ptr_bits = $clog2(`QUEUE_DEPTH);

   // payload storage
   mem_req_t mem [`QUEUE_DEPTH];

   logic [ptr_bits-1:0] wr_ptr;     // next free slot
   logic [ptr_bits-1:0] rd_ptr;     // head slot
   logic [ptr_bits:0]   count;      // one extra bit so full is representable

   logic do_push;
   logic do_pop;

   // a push into a full queue or a pop from an empty one is ignored
   assign do_push = push && !full;
   assign do_pop  = pop && !empty;

   // flags straight from the occupancy
   assign empty = (count == '0);
   assign full  = (count == (ptr_bits+1)'(`QUEUE_DEPTH));
   assign half  = (count >= (ptr_bits+1)'(`QUEUE_DEPTH / 2));

   // combinational head read
   assign head = mem[rd_ptr];

   // pointer and occupancy bookkeeping
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // both or neither leaves the level unchanged
         endcase
      end
   end

   // entry write into the storage array
   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= wr_req;
      end
   end

   // the newest row only means something while the queue holds an entry
   // and the steering logic qualifies it with empty and full
   always_ff @(posedge clk) begin
      if (do_push) begin
         last_row <= wr_req.row;
      end
   end

endmodule

`default_nettype wire

// File: design/sched_params.svh
// queue counts, depth and field widths for the scheduler front end, `include where needed
`ifndef SCHED_PARAMS_SVH
`define SCHED_PARAMS_SVH

// queue population
`define RD_QUEUES 4                          // read queues sit at the low indices
`define WR_QUEUES 3                          // write queues follow the read ones
`define NUM_QUEUES (`RD_QUEUES + `WR_QUEUES) // 7 queues in total

// per queue storage, keep it a power of two so the pointers wrap for free
`define QUEUE_DEPTH 4

// request fields
`define ROW_BITS 8                           // row address
`define COL_BITS 6                           // column address
`define TAG_BITS 4                           // request tag, returned untouched

// wide enough to name any of the NUM_QUEUES queues
`define QIDX_BITS 3

`endif

// File: design/sched_pkg.sv
// request and issue types shared by all scheduler blocks, imported with sched_pkg::*
`default_nettype none

`include "sched_params.svh"

package sched_pkg;

   // request type, decides read or write queue group
   typedef enum logic [0:0] {
      kind_read  = 1'b0,
      kind_write = 1'b1
   } req_kind_t;

   // one dram request as seen on the input port and stored in the queues
   typedef struct packed {
      req_kind_t              kind; // read / write
      logic [`ROW_BITS-1:0]   row;  // row address, used for hit steering
      logic [`COL_BITS-1:0]   col;  // column address
      logic [`TAG_BITS-1:0]   tag;  // opaque id for the requester
   } mem_req_t;

   // request handed to the memory side
   // src_queue lets the memory side do completion bookkeeping per queue
   typedef struct packed {
      mem_req_t               req;
      logic [`QIDX_BITS-1:0]  src_queue;
   } issue_t;

endpackage

`default_nettype wire

// File: design/sched_top.sv
// scheduler front end top: request queues, input steering and issue arbiter wired together
`default_nettype none

`include "sched_params.svh"

module sched_top import sched_pkg::*; (
   input  logic      clk,
   input  logic      arst_n,

   // request side
   input  logic      in_valid,
   output logic      in_ready,
   input  mem_req_t  in_req,

   // memory side
   output logic      out_valid,
   input  logic      out_ready,
   output issue_t    out_issue
);

   logic [`NUM_QUEUES-1:0]                  push;      // steering -> queues
   logic [`NUM_QUEUES-1:0]                  pop;       // arbiter -> queues
   logic [`NUM_QUEUES-1:0]                  empty;
   logic [`NUM_QUEUES-1:0]                  half;
   logic [`NUM_QUEUES-1:0]                  full;
   logic [`NUM_QUEUES-1:0][`ROW_BITS-1:0]   last_row;  // newest row per queue
   mem_req_t [`NUM_QUEUES-1:0]              heads;     // oldest entry per queue

   // reads in 0..RD_QUEUES-1, writes above
   for (genvar q = 0; q < `NUM_QUEUES; q++) begin : g_queue
      req_queue u_queue (
         .clk      (clk),
         .arst_n   (arst_n),
         .push     (push[q]),
         .pop      (pop[q]),
         .wr_req   (in_req),        // every queue sees the request, push picks one
         .head     (heads[q]),
         .empty    (empty[q]),
         .half     (half[q]),
         .full     (full[q]),
         .last_row (last_row[q])
      );
   end

   // input side queue choice
   cmd_steer u_steer (
      .in_valid (in_valid),
      .in_req   (in_req),
      .empty    (empty),
      .half     (half),
      .full     (full),
      .last_row (last_row),
      .in_ready (in_ready),
      .push     (push)
   );

   // output side drain
   issue_arbiter u_arb (
      .clk       (clk),
      .arst_n    (arst_n),
      .heads     (heads),
      .empty     (empty),
      .out_ready (out_ready),
      .out_valid (out_valid),
      .out_issue (out_issue),
      .pop       (pop)
   );

endmodule

`default_nettype wire

// File: dv/tb_clk_gen.sv
// clock and reset source for the scheduler testbench, instanced once by the testbench top
`default_nettype none

module tb_clk_gen #(
   parameter int period     = 8,   // clock period in time units
   parameter int rst_cycles = 2    // cycles with reset held low
) (
   output logic clk,
   output logic arst_n
);

   initial begin
      clk = 1'b0;
      forever #(period / 2) clk = ~clk;
   end

   // released on a falling edge, away from the sampling edge
   initial begin
      arst_n = 1'b0;
      #(period * rst_cycles) arst_n = 1'b1;
   end

endmodule

`default_nettype wire

// File: dv/tb_sched.sv
// testbench top that drives sched_top and checks its responses against a queue model
`default_nettype none

`include "sched_params.svh"

module tb_sched import sched_pkg::*; ();

   localparam int rand_cycles = 600;
   // per test budgets for reset, row hit, half level, back-pressure, random and final drain
   localparam int test_cycles = 4 + 80 + 90 + 110 + rand_cycles + 64;
   localparam int cycle_limit = test_cycles + 100;

   logic     clk;
   logic     arst_n;
   logic     in_valid;
   logic     in_ready;
   mem_req_t in_req;
   logic     out_valid;
   logic     out_ready;
   issue_t   out_issue;

   // model state with one queue per DUT queue
   mem_req_t mq [`NUM_QUEUES][$];
   int       rr_model = 0;        // search start of the round-robin
   bit       hold_model = 1'b0;   // a stalled grant is locked
   int       hold_idx_model = 0;
   int       last_dest = -1;      // model queue of the latest accepted request
   bit       in_fired = 1'b0;     // input transfer seen on the last rising edge
   bit       stall_seen = 1'b0;
   issue_t   prev_issue;
   int       n_in = 0;            // input handshakes seen on the DUT ports
   int       n_out = 0;           // output handshakes seen on the DUT ports
   int       errors = 0;
   int       checks = 0;
   int       tests_done = 0;
   int       cycles = 0;
   issue_t   held;

   tb_clk_gen u_clk (
      .clk    (clk),
      .arst_n (arst_n)
   );

   sched_top DUT (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .in_req    (in_req),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_issue (out_issue)
   );

   function automatic mem_req_t make_req(req_kind_t kind, int row, int col, int tag);
      mem_req_t r;
      r.kind = kind;
      r.row  = `ROW_BITS'(row);
      r.col  = `COL_BITS'(col);
      r.tag  = `TAG_BITS'(tag);
      return r;
   endfunction

   function automatic int model_total();
      int n;
      n = 0;
      for (int q = 0; q < `NUM_QUEUES; q++) begin
         n += mq[q].size();
      end
      return n;
   endfunction

   // room left anywhere in the request's group
   function automatic bit kind_space(req_kind_t k);
      int lo;
      int hi;
      lo = (k == kind_read) ? 0 : `RD_QUEUES;
      hi = (k == kind_read) ? `RD_QUEUES : `NUM_QUEUES;
      for (int q = lo; q < hi; q++) begin
         if (mq[q].size() < `QUEUE_DEPTH) return 1'b1;
      end
      return 1'b0;
   endfunction

   // greedy steering by hit, empty, below half and not full with the lowest index winning
   function automatic int steer_model(mem_req_t r);
      int lo;
      int hi;
      int n;
      lo = (r.kind == kind_read) ? 0 : `RD_QUEUES;
      hi = (r.kind == kind_read) ? `RD_QUEUES : `NUM_QUEUES;
      for (int step = 0; step < 4; step++) begin
         for (int q = lo; q < hi; q++) begin
            n = mq[q].size();
            if ((step == 0 && n > 0 && n < `QUEUE_DEPTH && mq[q][n-1].row == r.row) ||
                (step == 1 && n == 0) ||
                (step == 2 && n < `QUEUE_DEPTH / 2) ||
                (step == 3 && n < `QUEUE_DEPTH)) begin
               return q;
            end
         end
      end
      return -1;
   endfunction

   // queue the output should show or -1 when all are empty
   function automatic int arb_model();
      int q;
      if (hold_model) return hold_idx_model;   // stalled choice stays
      for (int k = 0; k < `NUM_QUEUES; k++) begin
         q = (rr_model + k) % `NUM_QUEUES;
         if (mq[q].size() != 0) return q;
      end
      return -1;
   endfunction

   task automatic check_val(string name, longint unsigned exp, longint unsigned act);
      checks++;
      assert (exp == act) else begin
         errors++;
         $display("[FAIL] time %0t %s expected 0x%0h actual 0x%0h", $time, name, exp, act);
      end
   endtask

   // output side compare and model update on every rising edge
   always @(posedge clk) begin : monitor
      int exp_q;
      int dest;
      if (arst_n) begin
         exp_q = arb_model();
         check_val("out_valid", exp_q >= 0, out_valid);
         if (stall_seen) check_val("out_issue", prev_issue, out_issue);  // held while stalled
         if (out_valid && exp_q >= 0) begin
            check_val("out_issue.src_queue", exp_q, out_issue.src_queue);
            check_val("out_issue.req", mq[exp_q][0], out_issue.req);
         end
         check_val("in_ready", kind_space(in_req.kind), in_ready);
         dest = -1;
         if (in_valid && in_ready) dest = steer_model(in_req);   // pre-edge flags
         if (out_valid && out_ready && exp_q >= 0) begin
            void'(mq[exp_q].pop_front());
            rr_model   = (exp_q + 1) % `NUM_QUEUES;
            hold_model = 1'b0;
         end else if (out_valid && exp_q >= 0) begin
            hold_model     = 1'b1;
            hold_idx_model = exp_q;
         end
         if (out_valid && out_ready) n_out++;
         if (in_valid && in_ready) n_in++;
         if (dest >= 0) begin
            mq[dest].push_back(in_req);
         end
         in_fired   = in_valid && in_ready;
         last_dest  = dest;
         stall_seen = out_valid && !out_ready;
         prev_issue = out_issue;
      end
   end

   // a waiting request may not vanish before it is taken
   assert property (@(posedge clk) disable iff (!arst_n) (out_valid && !out_ready) |=> out_valid)
      else begin
         errors++;
         $display("time %0t: out_valid dropped while a stalled request was waiting", $time);
      end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= cycle_limit) begin
         $display("timeout: run did not finish within %0d cycles", cycle_limit);
         $display("Simulation failed");
         $finish;
      end
   end

   // starts and ends on a falling edge
   task automatic send_req(input mem_req_t r, input int exp_dest);
      in_valid = 1'b1;
      in_req   = r;
      do @(negedge clk); while (!in_fired);
      in_valid = 1'b0;
      if (exp_dest >= 0) check_val("steer destination", exp_dest, last_dest);
   endtask

   task automatic drain();
      out_ready = 1'b1;
      while (model_total() != 0) @(negedge clk);
      check_val("out_valid", 0, out_valid);   // everything gone
      out_ready = 1'b0;
   endtask

   task automatic finish_test(string name);
      tests_done++;
      $display("test %0d %s finished, failures so far %0d", tests_done, name, errors);
   endtask

   initial begin
      in_valid  = 1'b0;
      in_req    = '0;
      out_ready = 1'b0;
      void'($urandom(32'h97b6f5fb));
      wait (arst_n);
      @(posedge clk);
      @(negedge clk);

      check_val("out_valid", 0, out_valid);
      check_val("in_ready", 1, in_ready);
      finish_test("reset state");

      // second read to the same row joins queue 0 and a new row opens queue 1
      send_req(make_req(kind_read, 'h21, 1, 1), 0);
      send_req(make_req(kind_read, 'h21, 2, 2), 0);
      send_req(make_req(kind_read, 'h5a, 3, 3), 1);
      drain();
      finish_test("row hit and empty queue");

      // distinct rows fill the empties first, then the queues below half, then any non-full one
      for (int i = 0; i < 9; i++) begin
         send_req(make_req(kind_read, 'h30 + i, i, i), i % `RD_QUEUES);
      end
      drain();
      finish_test("half level steering");

      for (int i = 0; i < `RD_QUEUES * `QUEUE_DEPTH; i++) begin
         send_req(make_req(kind_read, 'h60 + i, i, i), -1);
      end
      in_req.kind = kind_read;
      held        = out_issue;
      repeat (4) @(negedge clk);
      check_val("in_ready", 0, in_ready);     // read group full
      check_val("out_issue", held, out_issue);
      in_req.kind = kind_write;
      @(negedge clk);
      check_val("in_ready", 1, in_ready);     // write group still open
      drain();
      finish_test("back-pressure");

      // a request stays put until taken and rows come from a small set to get hits
      for (int c = 0; c < rand_cycles; c++) begin
         out_ready = ($urandom % 3) != 0;
         if (!in_valid || in_fired) begin
            in_valid = $urandom % 2;
            in_req   = make_req(req_kind_t'($urandom % 2), $urandom % 4, $urandom, $urandom);
         end
         @(negedge clk);
      end
      in_valid = 1'b0;
      drain();
      check_val("issued count", n_in, n_out);
      finish_test("random traffic");

      $display("tests %0d, checks %0d, failures %0d", tests_done, checks, errors);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# builds the scheduler testbench with Verilator, runs it and reports pass or fail

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f sim.f --top-module tb_sched -Mdir obj_dir -o simv > build.log 2>&1
if [ $? -ne 0 ]; then
   echo "build failed, see build.log"
   exit 1
fi

./obj_dir/simv > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
   echo "simulator exited with status $run_status"
   exit 1
fi

if grep -q "Simulation failed" sim.log; then
   exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
   echo "no result line in sim.log"
   exit 1
fi
exit 0

// File: sim.f
+incdir+design
design/sched_pkg.sv
design/req_queue.sv
design/cmd_steer.sv
design/issue_arbiter.sv
design/sched_top.sv
dv/tb_clk_gen.sv
dv/tb_sched.sv
